//--- design/div_clz.sv
`include "div_settings.svh"

module div_clz (
    input  logic [`DIV_WIDTH-1:0] value,
    output logic [`DIV_CLZ_W-1:0] count
);
    localparam int GRP_W  = 8;
    localparam int GRP_CW = $clog2(GRP_W);
    localparam int N_GRP  = `DIV_WIDTH / GRP_W;
    localparam int CW     = `DIV_CLZ_W;

    logic [N_GRP-1:0]  grp_nz;              // group holds a set bit
    logic [GRP_CW-1:0] grp_cnt [N_GRP];     // zeros above the top set bit in a group

    // first level: per byte priority encode
    always_comb begin
        for (int g = 0; g < N_GRP; g++) begin
            grp_nz[g]  = |value[g*GRP_W +: GRP_W];
            grp_cnt[g] = GRP_CW'(GRP_W - 1);
            for (int b = 0; b < GRP_W; b++) begin
                if (value[g*GRP_W + b]) begin
                    grp_cnt[g] = GRP_CW'(GRP_W - 1 - b); // higher bits win
                end
            end
        end
    end

    // second level: pick the most significant non-empty group
    always_comb begin
        count = '1; // zero input saturates, callers treat zero separately
        for (int g = 0; g < N_GRP; g++) begin
            if (grp_nz[g]) begin
                count = CW'((N_GRP - 1 - g) * GRP_W + grp_cnt[g]);
            end
        end
    end

endmodule

//--- design/div_control.sv
`include "div_settings.svh"

module div_control import div_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  div_op_e                 op,
    input  div_special_e            special_in,
    input  logic                    neg_quotient_in,
    input  logic                    neg_remainder_in,
    input  logic [`DIV_CLZ_W-2:0]   iter_count,
    output logic                    load,
    output logic                    step,
    output logic                    finish,
    output logic                    busy,
    output logic                    done,
    output div_special_e            special,
    output logic                    neg_quotient,
    output logic                    neg_remainder,
    output logic                    want_remainder
);
    logic                   accept;     // start while idle
    logic                   running;
    logic                   last_step;
    logic [`DIV_CLZ_W-2:0]  iter_left;  // iterations still to go, minus one

    assign accept    = start && !busy;
    assign load      = accept;
    assign step      = running;
    assign last_step = running && (iter_left == '0);

    // flags held for the whole request
    always_ff @(posedge clk) begin
        if (rst) begin
            special        <= SPC_NONE;
            neg_quotient   <= 1'b0;
            neg_remainder  <= 1'b0;
            want_remainder <= 1'b0;
        end else if (accept) begin
            special        <= special_in;
            neg_quotient   <= neg_quotient_in;
            neg_remainder  <= neg_remainder_in;
            want_remainder <= (op == OP_REM) || (op == OP_REMU);
        end
    end

    // bypassed requests never enter the run state
    always_ff @(posedge clk) begin
        if (rst) begin
            running   <= 1'b0;
            iter_left <= '0;
        end else if (accept) begin
            running   <= (special_in == SPC_NONE);
            iter_left <= iter_count;
        end else if (running) begin
            running   <= !last_step;
            iter_left <= iter_left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            finish <= 1'b0;
            done   <= 1'b0;
            busy   <= 1'b0;
        end else begin
            finish <= (accept && special_in != SPC_NONE) || last_step;
            done   <= finish; // result register loads on the same edge
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0; // drops after the done cycle
            end
        end
    end

    a_done_in_busy: assert property (@(posedge clk) disable iff (rst) done |-> busy)
        else $error("done outside a busy request");

    // a step in the finish cycle would mean the counter overran
    a_step_running: assert property (@(posedge clk) disable iff (rst)
        step |-> running && busy && !finish)
        else $error("step without an active run");

endmodule

//--- design/div_operand_prep.sv
`include "div_settings.svh"

module div_operand_prep import div_pkg::*; (
    input  div_op_e                 op,
    input  logic [`DIV_WIDTH-1:0]   dividend,
    input  logic [`DIV_WIDTH-1:0]   divisor,
    output logic [`DIV_WIDTH-1:0]   dividend_mag,
    output logic [`DIV_WIDTH-1:0]   divisor_mag,
    output logic [`DIV_CLZ_W-1:0]   align_shift,
    output logic [`DIV_CLZ_W-2:0]   iter_count,
    output div_special_e            special,
    output logic                    neg_quotient,
    output logic                    neg_remainder
);
    localparam logic [`DIV_WIDTH-1:0] MOST_NEG = {1'b1, {(`DIV_WIDTH-1){1'b0}}};
    localparam logic [`DIV_WIDTH-1:0] MINUS_ONE = {`DIV_WIDTH{1'b1}};

    logic                   signed_op;
    logic                   dividend_neg;
    logic                   divisor_neg;
    logic [`DIV_CLZ_W-1:0]  dividend_clz;
    logic [`DIV_CLZ_W-1:0]  divisor_clz;
    logic [`DIV_CLZ_W-1:0]  clz_delta;
    logic                   divisor_larger;

    assign signed_op    = (op == OP_DIV) || (op == OP_REM);
    assign dividend_neg = signed_op && dividend[`DIV_WIDTH-1];
    assign divisor_neg  = signed_op && divisor[`DIV_WIDTH-1];

    // most negative value maps onto itself, still correct read as unsigned
    assign dividend_mag = dividend_neg ? -dividend : dividend;
    assign divisor_mag  = divisor_neg ? -divisor : divisor;

    // quotient sign from xor of signs, remainder follows the dividend
    assign neg_quotient  = dividend_neg ^ divisor_neg;
    assign neg_remainder = dividend_neg;

    div_clz u_dividend_clz (
        .value (dividend_mag),
        .count (dividend_clz)
    );

    div_clz u_divisor_clz (
        .value (divisor_mag),
        .count (divisor_clz)
    );

    // a divisor no larger than the dividend never has fewer leading zeros
    assign clz_delta      = divisor_clz - dividend_clz;
    assign divisor_larger = divisor_mag > dividend_mag;

    // round down to even so each radix-4 step consumes two aligned bits
    assign align_shift = {clz_delta[`DIV_CLZ_W-1:1], 1'b0};
    assign iter_count  = clz_delta[`DIV_CLZ_W-1:1];

    always_comb begin
        if (divisor == '0) begin
            special = SPC_BY_ZERO;
        end else if (signed_op && dividend == MOST_NEG && divisor == MINUS_ONE) begin
            special = SPC_OVERFLOW;
        end else if (dividend == '0) begin
            special = SPC_ZERO_DIVIDEND;
        end else if (divisor_larger) begin
            special = SPC_SMALL;
        end else begin
            special = SPC_NONE;
        end
    end

endmodule

//--- design/div_pkg.sv
package div_pkg;

    // M extension divide ops in funct3 order, 0x4 base dropped
    typedef enum logic [1:0] {
        OP_DIV  = 2'b00,
        OP_DIVU = 2'b01,
        OP_REM  = 2'b10,
        OP_REMU = 2'b11
    } div_op_e;

    // requests that skip the iteration and finish in one step
    typedef enum logic [2:0] {
        SPC_NONE          = 3'd0,
        SPC_BY_ZERO       = 3'd1, // quotient all ones, remainder = dividend
        SPC_OVERFLOW      = 3'd2, // most negative / -1
        SPC_ZERO_DIVIDEND = 3'd3,
        SPC_SMALL         = 3'd4  // |divisor| > |dividend|
    } div_special_e;

endpackage

//--- design/div_radix4_core.sv
`include "div_settings.svh"

module div_radix4_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load,
    input  logic                    step,
    input  logic [`DIV_WIDTH-1:0]   dividend_mag,
    input  logic [`DIV_WIDTH-1:0]   divisor_mag,
    input  logic [`DIV_CLZ_W-1:0]   align_shift,
    output logic [`DIV_WIDTH-1:0]   quotient,
    output logic [`DIV_WIDTH-1:0]   remainder
);
    localparam int W  = `DIV_WIDTH;
    localparam int QB = `DIV_QBITS;

    logic [W-1:0]   shifted_divisor;
    logic [W+1:0]   try_2x;         // remainder - 2d, sign in the top bit
    logic [W+1:0]   try_1x;         // remainder - 3d or remainder - d
    logic [QB-1:0]  digit;
    logic [W-1:0]   remainder_next;

    assign try_2x   = {2'b00, remainder} - {1'b0, shifted_divisor, 1'b0};
    assign digit[1] = ~try_2x[W+1];

    // from remainder - 2d go one more down, or one back up
    assign try_1x = digit[1] ? try_2x - {2'b00, shifted_divisor}
                             : try_2x + {2'b00, shifted_divisor};
    assign digit[0] = ~try_1x[W+1];

    always_comb begin
        if (digit[0]) begin
            remainder_next = try_1x[W-1:0]; // digit 3 or 1
        end else if (digit[1]) begin
            remainder_next = try_2x[W-1:0]; // digit 2
        end else begin
            remainder_next = remainder;     // digit 0
        end
    end

    // divisor walks back down to its original position on the last step
    always_ff @(posedge clk) begin
        if (load) begin
            shifted_divisor <= divisor_mag << align_shift;
        end else if (step) begin
            shifted_divisor <= shifted_divisor >> QB;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            quotient  <= '0;
            remainder <= '0;
        end else if (load) begin
            quotient  <= '0;
            remainder <= dividend_mag;
        end else if (step) begin
            quotient  <= {quotient[W-QB-1:0], digit};
            remainder <= remainder_next;
        end
    end

    a_load_step_excl: assert property (@(posedge clk) disable iff (rst) !(load && step))
        else $error("load and step in the same cycle");

endmodule

//--- design/div_result_fixup.sv
`include "div_settings.svh"

module div_result_fixup import div_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    busy,
    input  logic [`DIV_WIDTH-1:0]   dividend,
    input  logic                    finish,
    input  div_special_e            special,
    input  logic                    neg_quotient,
    input  logic                    neg_remainder,
    input  logic                    want_remainder,
    input  logic [`DIV_WIDTH-1:0]   quotient,
    input  logic [`DIV_WIDTH-1:0]   remainder,
    output logic [`DIV_WIDTH-1:0]   result
);
    logic [`DIV_WIDTH-1:0] dividend_q;  // raw dividend, signed view kept
    logic [`DIV_WIDTH-1:0] raw_sel;
    logic                  negate;
    logic [`DIV_WIDTH-1:0] computed;
    logic [`DIV_WIDTH-1:0] substitute;

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            dividend_q <= dividend;
        end
    end

    assign raw_sel  = want_remainder ? remainder : quotient;
    assign negate   = want_remainder ? neg_remainder : neg_quotient;
    assign computed = negate ? -raw_sel : raw_sel;

    // RISC-V values for the bypassed cases
    always_comb begin
        case (special)
            SPC_BY_ZERO:  substitute = want_remainder ? dividend_q : {`DIV_WIDTH{1'b1}};
            SPC_OVERFLOW: substitute = want_remainder ? '0 : dividend_q;
            SPC_SMALL:    substitute = want_remainder ? dividend_q : '0;
            default:      substitute = '0; // zero dividend
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else if (finish) begin
            result <= (special == SPC_NONE) ? computed : substitute;
        end
    end

endmodule

//--- design/div_settings.svh
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// operand and result width
`define DIV_WIDTH 32

// width of a leading-zero count, log2 of the data width
`define DIV_CLZ_W 5

// quotient bits retired per iteration, radix 4
`define DIV_QBITS 2

`endif

//--- design/div_unit.sv
`include "div_settings.svh"

module div_unit import div_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  div_op_e                 op,
    input  logic [`DIV_WIDTH-1:0]   dividend,
    input  logic [`DIV_WIDTH-1:0]   divisor,
    input  logic                    start,
    output logic                    busy,
    output logic                    done,
    output logic [`DIV_WIDTH-1:0]   result
);
    logic [`DIV_WIDTH-1:0]  dividend_mag;
    logic [`DIV_WIDTH-1:0]  divisor_mag;
    logic [`DIV_CLZ_W-1:0]  align_shift;
    logic [`DIV_CLZ_W-2:0]  iter_count;
    div_special_e           prep_special;   // unlatched, from the live operands
    logic                   prep_neg_quotient;
    logic                   prep_neg_remainder;

    logic                   load;
    logic                   step;
    logic                   finish;
    div_special_e           special;
    logic                   neg_quotient;
    logic                   neg_remainder;
    logic                   want_remainder;
    logic [`DIV_WIDTH-1:0]  quotient;
    logic [`DIV_WIDTH-1:0]  remainder;

    div_operand_prep u_prep (
        .op            (op),
        .dividend      (dividend),
        .divisor       (divisor),
        .dividend_mag  (dividend_mag),
        .divisor_mag   (divisor_mag),
        .align_shift   (align_shift),
        .iter_count    (iter_count),
        .special       (prep_special),
        .neg_quotient  (prep_neg_quotient),
        .neg_remainder (prep_neg_remainder)
    );

    div_control u_control (
        .clk              (clk),
        .rst              (rst),
        .start            (start),
        .op               (op),
        .special_in       (prep_special),
        .neg_quotient_in  (prep_neg_quotient),
        .neg_remainder_in (prep_neg_remainder),
        .iter_count       (iter_count),
        .load             (load),
        .step             (step),
        .finish           (finish),
        .busy             (busy),
        .done             (done),
        .special          (special),
        .neg_quotient     (neg_quotient),
        .neg_remainder    (neg_remainder),
        .want_remainder   (want_remainder)
    );

    div_radix4_core u_core (
        .clk          (clk),
        .rst          (rst),
        .load         (load),
        .step         (step),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .align_shift  (align_shift),
        .quotient     (quotient),
        .remainder    (remainder)
    );

    div_result_fixup u_fixup (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .busy           (busy),
        .dividend       (dividend),
        .finish         (finish),
        .special        (special),
        .neg_quotient   (neg_quotient),
        .neg_remainder  (neg_remainder),
        .want_remainder (want_remainder),
        .quotient       (quotient),
        .remainder      (remainder),
        .result         (result)
    );

endmodule

//--- list.f
+incdir+design
design/div_pkg.sv
design/div_clz.sv
design/div_operand_prep.sv
design/div_control.sv
design/div_radix4_core.sv
design/div_result_fixup.sv
design/div_unit.sv
test/div_tb.sv

//--- test/div_tb.sv
`include "div_settings.svh"

module div_tb import div_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int W            = `DIV_WIDTH;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_REQUESTS = 500;
    localparam int MAX_LATENCY  = 18;  // edges from accepted start to done
    localparam int MAX_GAP      = 6;   // idle cycles between requests

    localparam logic [W-1:0] MOST_NEG  = {1'b1, {(W-1){1'b0}}};
    localparam logic [W-1:0] MINUS_ONE = {W{1'b1}};

    logic          clk;
    logic          rst;
    div_op_e       op;
    logic [W-1:0]  dividend;
    logic [W-1:0]  divisor;
    logic          start;
    logic          busy;
    logic          done;
    logic [W-1:0]  result;

    integer        seed;
    logic [W-1:0]  prev_result;        // last value seen at done
    string         cur_request;
    div_op_e       all_ops [4] = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    logic [W-1:0]  a;
    logic [W-1:0]  b;
    logic [31:0]   op_sel;

    div_unit DUT (
        .clk      (clk),
        .rst      (rst),
        .op       (op),
        .dividend (dividend),
        .divisor  (divisor),
        .start    (start),
        .busy     (busy),
        .done     (done),
        .result   (result)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [W-1:0] expected,
                               input logic [W-1:0] actual);
        assert (actual === expected)
        else begin
            $display("** Error %s: expected %h, actual %h (%s)", name, expected, actual,
                     cur_request);
            abort_run();
        end
    endtask

    // RISC-V M extension divide rules
    function automatic logic [W-1:0] model_result(input div_op_e o, input logic [W-1:0] x,
                                                  input logic [W-1:0] y);
        logic signed [W-1:0] sx;
        logic signed [W-1:0] sy;
        sx = x;
        sy = y;
        case (o)
            OP_DIVU: return (y == '0) ? MINUS_ONE : x / y;
            OP_REMU: return (y == '0) ? x : x % y;
            OP_DIV: begin
                if (y == '0) return MINUS_ONE;
                if (x == MOST_NEG && y == MINUS_ONE) return x;
                return sx / sy;        // truncates toward zero
            end
            default: begin
                if (y == '0) return x;
                if (x == MOST_NEG && y == MINUS_ONE) return '0;
                return sx % sy;        // sign follows the dividend
            end
        endcase
    endfunction

    // requests that should skip the iteration entirely
    function automatic bit model_bypass(input div_op_e o, input logic [W-1:0] x,
                                        input logic [W-1:0] y);
        bit           sgn;
        logic [W-1:0] mx;
        logic [W-1:0] my;
        sgn = (o == OP_DIV) || (o == OP_REM);
        mx  = (sgn && x[W-1]) ? -x : x;
        my  = (sgn && y[W-1]) ? -y : y;
        if (y == '0) return 1'b1;
        if (sgn && x == MOST_NEG && y == MINUS_ONE) return 1'b1;
        if (x == '0) return 1'b1;
        return my > mx; // divisor magnitude exceeds the dividend's
    endfunction

    // biased toward corner values and short operands
    function automatic logic [W-1:0] pick_operand();
        int           sel;
        logic [W-1:0] r;
        sel = {$random(seed)} % 8;
        r   = $random(seed);
        case (sel)
            0:       return '0;
            1:       return MINUS_ONE;
            2:       return MOST_NEG;
            3:       return r & 32'hf;
            4:       return -(r & 32'hf);
            5:       return r >> ({$random(seed)} % W);
            default: return r;
        endcase
    endfunction

    task automatic run_request(input div_op_e o, input logic [W-1:0] x, input logic [W-1:0] y);
        logic [W-1:0] expected;
        int           lat;
        bit           got_done;
        expected    = model_result(o, x, y);
        cur_request = $sformatf("op %s, dividend %h, divisor %h", o.name(), x, y);
        @(posedge clk);
        op       <= o;
        dividend <= x;
        divisor  <= y;
        start    <= 1'b1;
        @(posedge clk);                // accepted on this edge
        start    <= 1'b0;
        dividend <= $random(seed);     // operands need not be held
        divisor  <= $random(seed);
        op       <= div_op_e'(op_sel[3:2]);
        lat      = 1;                  // the accepting edge counts as the first
        got_done = 1'b0;
        while (!got_done) begin
            @(negedge clk);
            check_value("busy", 1, busy);
            if (done) begin
                got_done = 1'b1;
            end else begin
                check_value("result", prev_result, result); // old result still held
                lat++;
                if (lat > MAX_LATENCY) begin
                    $display("timeout: no done within %0d cycles of start (%s)",
                             MAX_LATENCY, cur_request);
                    abort_run();
                end
            end
        end
        check_value("result", expected, result);
        if (model_bypass(o, x, y)) begin
            check_value("latency", 2, lat);
        end
        prev_result = result;
        @(negedge clk);
        check_value("done", 0, done);  // single cycle pulse
        check_value("busy", 0, busy);
        check_value("result", prev_result, result);
    endtask

    task automatic idle_gap(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("done", 0, done);
            check_value("busy", 0, busy);
            check_value("result", prev_result, result);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        start       = 1'b0;
        op          = OP_DIV;
        dividend    = '0;
        divisor     = '0;
        seed        = 32'h1d9be0b2;
        prev_result = '0;
        op_sel      = '0;
        cur_request = "reset";

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("busy", 0, busy);
        check_value("done", 0, done);
        check_value("result", 0, result);

        // corner cases for every op
        for (int i = 0; i < 4; i++) begin
            run_request(all_ops[i], $random(seed), '0);
            run_request(all_ops[i], '0, '0);
            run_request(all_ops[i], MOST_NEG, MINUS_ONE);
            run_request(all_ops[i], '0, $random(seed));
            run_request(all_ops[i], 32'h7fffffff, 32'h1);
            idle_gap({$random(seed)} % MAX_GAP);
        end

        for (int n = 0; n < NUM_REQUESTS; n++) begin
            op_sel = $random(seed);
            a      = pick_operand();
            b      = pick_operand();
            if (({$random(seed)} % 6) == 0) begin
                b = a + ($random(seed) % 4); // near equal operands
            end
            run_request(div_op_e'(op_sel[1:0]), a, b);
            idle_gap({$random(seed)} % MAX_GAP);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
